// ==== rtl/mouse_pkg.sv ====
// widths, isa and fsm enums, bus and decode structs for the mouse core
`default_nettype none

package mouse_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths

  localparam int unsigned xlen = 32;
  localparam int unsigned xlog = $clog2(xlen);  // shift amount bits

  typedef logic [xlen-1:0] word_t;

  //////////////////////////////////////////////////////////////////////
  // isa encodings

  // base opcode map, instruction bits [6:5]_[4:2]
  typedef enum logic [4:0] {
    op_load  = 5'b00_000,
    op_imm   = 5'b00_100,
    op_auipc = 5'b00_101,
    op_store = 5'b01_000,
    op_reg   = 5'b01_100,
    op_lui   = 5'b01_101,
    op_jal   = 5'b11_011
  } opcode_t;

  typedef enum logic [2:0] {
    fn_add  = 3'b000,  // alt selects sub for op_reg
    fn_sl   = 3'b001,
    fn_slt  = 3'b010,
    fn_sltu = 3'b011,
    fn_xor  = 3'b100,
    fn_sr   = 3'b101,  // alt selects arithmetic shift
    fn_or   = 3'b110,
    fn_and  = 3'b111
  } fn3_t;

  //////////////////////////////////////////////////////////////////////
  // control

  typedef enum logic [1:0] {
    st_fetch   = 2'd0,  // issue fetch
    st_decode  = 2'd1,  // instruction on bus, rs1 read or rd write
    st_operand = 2'd2,  // rs2 read or load
    st_execute = 2'd3   // write-back or store
  } state_t;

  // gpr access phases all have bit 2 set
  typedef enum logic [2:0] {
    ph_if  = 3'b000,
    ph_rs1 = 3'b101,
    ph_rs2 = 3'b110,
    ph_mld = 3'b001,
    ph_mst = 3'b010,
    ph_wb  = 3'b100
  } phase_t;

  typedef enum logic [1:0] {
    ar_add,
    ar_sub,
    ar_slt,
    ar_sltu
  } arith_op_t;

  //////////////////////////////////////////////////////////////////////
  // bus and decode bundles

  typedef struct packed {
    logic  vld;
    logic  wen;
    logic  xen;  // instruction fetch
    word_t adr;
    word_t wdt;
  } bus_req_t;

  typedef struct packed {
    word_t rdt;
    logic  rdy;
  } bus_rsp_t;

  typedef struct packed {
    opcode_t    opc;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    fn3_t       fn3;
    logic       alt;  // funct7[5]
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;
    word_t      imm_j;
  } dec_t;

endpackage

`default_nettype wire

// ==== rtl/mouse_arith.sv ====
// 33-bit adder for add, sub, set-less-than and address calculation
`default_nettype none
`timescale 1ns/100ps

module mouse_arith (
  input  mouse_pkg::arith_op_t     mode,
  input  mouse_pkg::word_t         a,
  input  mouse_pkg::word_t         b,
  output logic [mouse_pkg::xlen:0] sum  // bit 32 is less-than
);

  logic [mouse_pkg::xlen:0] ext_a;
  logic [mouse_pkg::xlen:0] ext_b;
  logic                     cin;  // carry in

  // operand extension and inversion
  always_comb begin
    unique case (mode)
      mouse_pkg::ar_add: begin
        ext_a = {a[mouse_pkg::xlen-1], a};
        ext_b = {b[mouse_pkg::xlen-1], b};
        cin   = 1'b0;
      end
      // signed difference, sign lands in bit 32
      mouse_pkg::ar_sub, mouse_pkg::ar_slt: begin
        ext_a = {a[mouse_pkg::xlen-1], a};
        ext_b = ~{b[mouse_pkg::xlen-1], b};
        cin   = 1'b1;
      end
      mouse_pkg::ar_sltu: begin
        ext_a = {1'b0, a};
        ext_b = ~{1'b0, b};  // borrow shows in bit 32
        cin   = 1'b1;
      end
    endcase
  end

  assign sum = ext_a + ext_b + {{mouse_pkg::xlen{1'b0}}, cin};

endmodule

`default_nettype wire

// ==== rtl/mouse_bitwise.sv ====
// logic operations and bit-reversing barrel shifter
`default_nettype none
`timescale 1ns/100ps

module mouse_bitwise (
  input  mouse_pkg::fn3_t  fn3,
  input  logic             alt,  // arithmetic right shift
  input  mouse_pkg::word_t a,
  input  mouse_pkg::word_t b,
  output mouse_pkg::word_t result
);

  mouse_pkg::word_t                shf_in;
  logic signed [mouse_pkg::xlen:0] shf_ext;  // one extra fill bit
  logic signed [mouse_pkg::xlen:0] shf_out;

  // reverse bit order
  function automatic mouse_pkg::word_t bitrev(input mouse_pkg::word_t val);
    mouse_pkg::word_t rev;
    for (int i = 0; i < mouse_pkg::xlen; i++) begin
      rev[i] = val[mouse_pkg::xlen-1-i];
    end
    return rev;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // barrel shifter

  // left shift = reversed right shift
  assign shf_in  = (fn3 == mouse_pkg::fn_sl) ? bitrev(a) : a;
  assign shf_ext = {alt & shf_in[mouse_pkg::xlen-1], shf_in};
  assign shf_out = shf_ext >>> b[mouse_pkg::xlog-1:0];

  //////////////////////////////////////////////////////////////////////
  // result select

  always_comb begin
    unique case (fn3)
      mouse_pkg::fn_and: result = a & b;
      mouse_pkg::fn_or:  result = a | b;
      mouse_pkg::fn_xor: result = a ^ b;
      mouse_pkg::fn_sr:  result = shf_out[mouse_pkg::xlen-1:0];
      mouse_pkg::fn_sl:  result = bitrev(shf_out[mouse_pkg::xlen-1:0]);
      default:           result = '0;  // adder ops, not used
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/mouse_decoder.sv ====
// instruction buffer, field extraction and immediate generation
`default_nettype none
`timescale 1ns/100ps

module mouse_decoder (
  input  logic              clk,
  input  logic              rst,
  input  mouse_pkg::state_t state,
  input  logic              load,  // fetch response transfer
  input  mouse_pkg::word_t  rdt,
  output mouse_pkg::dec_t   dec
);

  mouse_pkg::word_t ibuf;  // held instruction
  mouse_pkg::word_t ins;   // live or held

  //////////////////////////////////////////////////////////////////////
  // instruction buffer

  // resets to jal x0, 0 so the first fetch lands on the reset pc
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      ibuf <= 32'h0000_006f;
    end else if (load) begin
      ibuf <= rdt;
    end
  end

  // bus data only valid as instruction during decode
  assign ins = (state == mouse_pkg::st_decode) ? rdt : ibuf;

  //////////////////////////////////////////////////////////////////////
  // fields and immediates

  always_comb begin
    dec.opc   = mouse_pkg::opcode_t'(ins[6:2]);  // [1:0] ignored
    dec.rd    = ins[11:7];
    dec.rs1   = ins[19:15];
    dec.rs2   = ins[24:20];
    dec.fn3   = mouse_pkg::fn3_t'(ins[14:12]);
    dec.alt   = ins[30];
    // sign extended from bit 31 in every format except u
    dec.imm_i = {{21{ins[31]}}, ins[30:20]};
    dec.imm_s = {{21{ins[31]}}, ins[30:25], ins[11:7]};
    dec.imm_u = {ins[31:12], 12'd0};
    dec.imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
  end

  // program must stay inside the kept subset
  a_opcode_kept: assert property (
    @(posedge clk) disable iff (rst)
    load |-> dec.opc inside {mouse_pkg::op_load, mouse_pkg::op_imm,
                             mouse_pkg::op_auipc, mouse_pkg::op_store,
                             mouse_pkg::op_reg, mouse_pkg::op_lui,
                             mouse_pkg::op_jal}
  ) else $error("fetched opcode outside supported set");

endmodule

`default_nettype wire

// ==== rtl/mouse_sequencer.sv ====
// four-state FSM, pc, operand buffer, bus request and write-back select
`default_nettype none
`timescale 1ns/100ps

module mouse_sequencer #(
  parameter mouse_pkg::word_t rst_adr = 32'h8000_0000,  // reset pc
  parameter mouse_pkg::word_t gpr_adr = 32'h803f_ff80   // gpr window base
)(
  input  logic                     clk,
  input  logic                     rst,
  input  mouse_pkg::dec_t          dec,
  output mouse_pkg::bus_req_t      req,
  input  mouse_pkg::bus_rsp_t      rsp,
  output mouse_pkg::state_t        state,
  output logic                     load,
  output mouse_pkg::arith_op_t     arith_mode,
  output mouse_pkg::word_t         arith_a,
  output mouse_pkg::word_t         arith_b,
  input  logic [mouse_pkg::xlen:0] sum,
  output mouse_pkg::word_t         bit_a,
  output mouse_pkg::word_t         bit_b,
  input  mouse_pkg::word_t         bit_result
);

  mouse_pkg::state_t nxt;
  mouse_pkg::phase_t pha;
  logic              bus_vld;  // low for one cycle after reset
  logic              bvc;      // access is real, x0 skipped
  logic              bvr;      // previous access was real
  logic              rdy;
  logic              trn;      // step completes
  mouse_pkg::word_t  rdt;      // read data, zero for skipped reads
  mouse_pkg::word_t  pc;
  mouse_pkg::word_t  buf_dat;  // rs1 held across rs2 read
  mouse_pkg::word_t  adr;
  mouse_pkg::word_t  wdt;
  mouse_pkg::word_t  alu_val;

  // gpr n lives at base + 4n
  function automatic mouse_pkg::word_t gpr_slot(input logic [4:0] idx);
    return {gpr_adr[mouse_pkg::xlen-1:7], idx, 2'b00};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // bus handshake

  assign rdy  = bvc ? rsp.rdy : 1'b1;  // skipped access never waits
  assign trn  = bus_vld & rdy;
  assign rdt  = bvr ? rsp.rdt : '0;
  assign load = trn & (state == mouse_pkg::st_decode);

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      bus_vld <= 1'b0;
      state   <= mouse_pkg::st_fetch;
      bvr     <= 1'b0;
      pc      <= rst_adr;
    end else begin
      bus_vld <= 1'b1;
      if (trn) begin
        state <= nxt;
        bvr   <= bvc;
        if (state == mouse_pkg::st_fetch) begin
          pc <= sum[mouse_pkg::xlen-1:0];  // address just fetched
        end
      end
    end
  end

  // rs1 arrives during operand state
  always_ff @(posedge clk) begin
    if (trn && (state == mouse_pkg::st_operand)) begin
      buf_dat <= rdt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // FSM, operands and phase

  always_comb begin
    nxt        = mouse_pkg::st_fetch;
    pha        = mouse_pkg::ph_if;
    arith_mode = mouse_pkg::ar_add;
    arith_a    = pc;
    arith_b    = 32'd4;  // next sequential pc
    bit_a      = '0;
    bit_b      = '0;
    wdt        = '0;
    unique case (state)
      mouse_pkg::st_fetch: begin
        nxt = mouse_pkg::st_decode;
        if (dec.opc == mouse_pkg::op_jal) begin
          arith_b = dec.imm_j;
        end
      end
      mouse_pkg::st_decode: begin
        case (dec.opc)
          mouse_pkg::op_lui: begin
            pha = mouse_pkg::ph_wb;
            wdt = dec.imm_u;
          end
          mouse_pkg::op_auipc: begin
            pha     = mouse_pkg::ph_wb;
            arith_b = dec.imm_u;
            wdt     = sum[mouse_pkg::xlen-1:0];
          end
          mouse_pkg::op_jal: begin
            pha = mouse_pkg::ph_wb;
            wdt = sum[mouse_pkg::xlen-1:0];  // link pc+4
          end
          mouse_pkg::op_imm: begin
            nxt = mouse_pkg::st_execute;  // no rs2
            pha = mouse_pkg::ph_rs1;
          end
          mouse_pkg::op_load, mouse_pkg::op_store, mouse_pkg::op_reg: begin
            nxt = mouse_pkg::st_operand;
            pha = mouse_pkg::ph_rs1;
          end
          // unknown opcode, harmless read then next fetch
          default: pha = mouse_pkg::ph_rs1;
        endcase
      end
      mouse_pkg::st_operand: begin
        nxt = mouse_pkg::st_execute;
        if (dec.opc == mouse_pkg::op_load) begin
          pha     = mouse_pkg::ph_mld;
          arith_a = rdt;  // rs1 straight off the bus
          arith_b = dec.imm_i;
        end else begin
          pha = mouse_pkg::ph_rs2;
        end
      end
      mouse_pkg::st_execute: begin
        case (dec.opc)
          mouse_pkg::op_store: begin
            pha     = mouse_pkg::ph_mst;
            arith_a = buf_dat;
            arith_b = dec.imm_s;
            wdt     = rdt;  // rs2
          end
          mouse_pkg::op_load: begin
            pha = mouse_pkg::ph_wb;
            wdt = rdt;
          end
          default: begin
            pha = mouse_pkg::ph_wb;
            // op: rs1 buffered, rs2 on bus; op-imm: rs1 on bus
            arith_a = (dec.opc == mouse_pkg::op_reg) ? buf_dat : rdt;
            arith_b = (dec.opc == mouse_pkg::op_reg) ? rdt : dec.imm_i;
            bit_a   = arith_a;
            bit_b   = arith_b;
            case (dec.fn3)
              mouse_pkg::fn_add: begin
                if ((dec.opc == mouse_pkg::op_reg) && dec.alt) begin
                  arith_mode = mouse_pkg::ar_sub;
                end
              end
              mouse_pkg::fn_slt:  arith_mode = mouse_pkg::ar_slt;
              mouse_pkg::fn_sltu: arith_mode = mouse_pkg::ar_sltu;
              default:            arith_mode = mouse_pkg::ar_add;
            endcase
            wdt = alu_val;
          end
        endcase
      end
    endcase
  end

  // write-back select
  always_comb begin
    case (dec.fn3)
      mouse_pkg::fn_add:  alu_val = sum[mouse_pkg::xlen-1:0];
      mouse_pkg::fn_slt,
      mouse_pkg::fn_sltu: alu_val = {31'd0, sum[mouse_pkg::xlen]};
      default:            alu_val = bit_result;  // logic and shifts
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // bus request

  // address by phase, x0 accesses dropped from the bus
  always_comb begin
    bvc = 1'b1;
    unique case (pha)
      mouse_pkg::ph_rs1: begin
        adr = gpr_slot(dec.rs1);
        bvc = |dec.rs1;
      end
      mouse_pkg::ph_rs2: begin
        adr = gpr_slot(dec.rs2);
        bvc = |dec.rs2;
      end
      mouse_pkg::ph_wb: begin
        adr = gpr_slot(dec.rd);
        bvc = |dec.rd;
      end
      default: adr = sum[mouse_pkg::xlen-1:0];  // fetch, load, store
    endcase
  end

  always_comb begin
    req.vld = bus_vld & bvc;
    req.wen = (pha == mouse_pkg::ph_wb) || (pha == mouse_pkg::ph_mst);
    req.xen = (pha == mouse_pkg::ph_if);
    req.adr = adr;
    req.wdt = wdt;
  end

  // memory must hold rdt until the next transfer for this to hold
  a_req_stable: assert property (
    @(posedge clk) disable iff (rst)
    req.vld && !rsp.rdy |=> $stable(req)
  ) else $error("bus request changed while stalled");

endmodule

`default_nettype wire

// ==== rtl/mouse_top.sv ====
// mouse core top level, sequencer with decoder, adder and bitwise unit
`default_nettype none
`timescale 1ns/100ps

module mouse_top #(
  parameter mouse_pkg::word_t rst_adr = 32'h8000_0000,
  parameter mouse_pkg::word_t gpr_adr = 32'h803f_ff80  // 128-byte aligned
)(
  input  logic                clk,
  input  logic                rst,
  output mouse_pkg::bus_req_t bus_req,
  input  mouse_pkg::bus_rsp_t bus_rsp
);

  mouse_pkg::state_t        state;
  logic                     load;
  mouse_pkg::dec_t          dec;
  mouse_pkg::arith_op_t     arith_mode;
  mouse_pkg::word_t         arith_a;
  mouse_pkg::word_t         arith_b;
  logic [mouse_pkg::xlen:0] sum;
  mouse_pkg::word_t         bit_a;
  mouse_pkg::word_t         bit_b;
  mouse_pkg::word_t         bit_result;

  mouse_sequencer #(
    .rst_adr (rst_adr),
    .gpr_adr (gpr_adr)
  ) u_seq (
    .clk        (clk),
    .rst        (rst),
    .dec        (dec),
    .req        (bus_req),
    .rsp        (bus_rsp),
    .state      (state),
    .load       (load),
    .arith_mode (arith_mode),
    .arith_a    (arith_a),
    .arith_b    (arith_b),
    .sum        (sum),
    .bit_a      (bit_a),
    .bit_b      (bit_b),
    .bit_result (bit_result)
  );

  // instruction word comes straight off the bus
  mouse_decoder u_dec (
    .clk   (clk),
    .rst   (rst),
    .state (state),
    .load  (load),
    .rdt   (bus_rsp.rdt),
    .dec   (dec)
  );

  mouse_arith u_arith (
    .mode (arith_mode),
    .a    (arith_a),
    .b    (arith_b),
    .sum  (sum)
  );

  mouse_bitwise u_bitwise (
    .fn3    (dec.fn3),
    .alt    (dec.alt),
    .a      (bit_a),
    .b      (bit_b),
    .result (bit_result)
  );

endmodule

`default_nettype wire

// ==== sim/tb_memory.sv ====
// bus memory model with program, data and gpr regions, random ready and transfer log
`default_nettype none
`timescale 1ns/100ps

module tb_memory #(
  parameter mouse_pkg::word_t rst_adr  = 32'h8000_0000,
  parameter mouse_pkg::word_t gpr_adr  = 32'h803f_ff80,
  parameter mouse_pkg::word_t data_adr = 32'h8000_1000
)(
  input  logic                clk,
  input  logic                rst,
  input  logic                bp_en,  // random ready when set
  input  mouse_pkg::bus_req_t req,
  output mouse_pkg::bus_rsp_t rsp
);

  mouse_pkg::word_t    prog [64];     // written by the testbench only
  mouse_pkg::word_t    data [64];
  mouse_pkg::word_t    gpr  [32];     // register window
  mouse_pkg::word_t    rd_q;          // data of the last read transfer
  mouse_pkg::word_t    lcg_state = 32'd64;
  mouse_pkg::word_t    last_fetch;
  mouse_pkg::word_t    data_off;
  logic                fetch_seen;
  logic                halted;        // same fetch address twice in a row
  mouse_pkg::bus_req_t trace [$];     // every completed transfer

  // scrambled address, every bit matters
  function automatic mouse_pkg::word_t fill_word(input mouse_pkg::word_t adr);
    return {adr[15:0], adr[31:16]} ^ 32'h5a5a_a5a5;
  endfunction

  function automatic mouse_pkg::word_t lcg_next(input mouse_pkg::word_t s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic mouse_pkg::word_t read_word(input mouse_pkg::word_t adr);
    mouse_pkg::word_t off;
    off = adr - rst_adr;
    if (adr[31:7] == gpr_adr[31:7]) return gpr[adr[6:2]];
    if (off < 32'd256) return prog[off[7:2]];
    off = adr - data_adr;
    if (off < 32'd256) return data[off[7:2]];
    return fill_word(adr);  // unmapped
  endfunction

  assign data_off = req.adr - data_adr;

  initial rsp = '0;

  //////////////////////////////////////////////////////////////////////
  // transfers complete on the rising edge

  always @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 64; i++) begin
        data[i] <= fill_word(data_adr + 4 * i);
      end
      for (int i = 0; i < 32; i++) begin
        gpr[i] <= fill_word(gpr_adr + 4 * i);  // x0 slot too, never read
      end
      rd_q       <= '0;
      last_fetch <= '0;
      fetch_seen <= 1'b0;
      halted     <= 1'b0;
      trace.delete();
    end else if (req.vld && rsp.rdy) begin
      trace.push_back(req);
      if (req.wen) begin
        if (req.adr[31:7] == gpr_adr[31:7]) begin
          gpr[req.adr[6:2]] <= req.wdt;
        end else if (data_off < 32'd256) begin
          data[data_off[7:2]] <= req.wdt;
        end
      end else begin
        rd_q <= read_word(req.adr);
      end
      if (req.xen) begin
        if (fetch_seen && (req.adr == last_fetch)) begin
          halted <= 1'b1;  // jump to self
        end
        last_fetch <= req.adr;
        fetch_seen <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response driven on the falling edge, data held until next read

  always @(negedge clk) begin : drive_rsp
    mouse_pkg::word_t nxt;
    nxt     = lcg_next(lcg_state);
    rsp.rdt <= rd_q;
    if (bp_en) begin
      lcg_state <= nxt;
      rsp.rdy   <= nxt[20];  // upper bits, low ones cycle fast
    end else begin
      rsp.rdy <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_mouse.sv ====
// testbench for the mouse core: clock, reset, watchdog, encoders, checks and directed tests
`default_nettype none
`timescale 1ns/100ps

module tb_mouse;

  localparam mouse_pkg::word_t rst_adr  = 32'h8000_0000;
  localparam mouse_pkg::word_t gpr_adr  = 32'h803f_ff80;
  localparam mouse_pkg::word_t data_adr = 32'h8000_1000;
  localparam int               n_runs     = 8;
  localparam int               run_cycles = 2000;

  // rv32i major opcodes
  localparam logic [6:0] opc_lui   = 7'b0110111;
  localparam logic [6:0] opc_auipc = 7'b0010111;
  localparam logic [6:0] opc_jal   = 7'b1101111;
  localparam logic [6:0] opc_imm   = 7'b0010011;
  localparam logic [6:0] opc_op    = 7'b0110011;
  localparam logic [6:0] opc_load  = 7'b0000011;
  localparam logic [6:0] opc_store = 7'b0100011;

  logic                clk;
  logic                rst;
  logic                bp_en;
  mouse_pkg::bus_req_t bus_req;
  mouse_pkg::bus_rsp_t bus_rsp;

  mouse_pkg::word_t prog_q   [$];  // program under construction
  mouse_pkg::word_t st_adr_q [$];  // expected stores, in order
  mouse_pkg::word_t st_dat_q [$];

  mouse_top #(.rst_adr(rst_adr), .gpr_adr(gpr_adr)) dut (
    .clk     (clk),
    .rst     (rst),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp)
  );

  tb_memory #(.rst_adr(rst_adr), .gpr_adr(gpr_adr), .data_adr(data_adr)) mem (
    .clk   (clk),
    .rst   (rst),
    .bp_en (bp_en),
    .req   (bus_req),
    .rsp   (bus_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(n_runs * run_cycles * 10);
    $display("timeout: the tests did not finish within %0d cycles", n_runs * run_cycles);
    $display("Checks failed");
    $fatal(1);
  end

  //////////////////////////////////////////////////////////////////////
  // reporting

  task automatic check(input string name, input mouse_pkg::word_t got,
                       input mouse_pkg::word_t exp);
    if (got !== exp) begin
      $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic report_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_gpr(input int n, input mouse_pkg::word_t exp);
    check($sformatf("x%0d", n), mem.gpr[n], exp);
  endtask

  //////////////////////////////////////////////////////////////////////
  // instruction encoders

  function automatic mouse_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic mouse_pkg::word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic mouse_pkg::word_t enc_s(input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};  // sw only
  endfunction

  function automatic mouse_pkg::word_t enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                             input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic mouse_pkg::word_t enc_j(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  function automatic mouse_pkg::word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic mouse_pkg::word_t flag(input logic c);
    return c ? 32'd1 : 32'd0;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // program handling and log scans

  task automatic new_program;
    prog_q.delete();
    st_adr_q.delete();
    st_dat_q.delete();
  endtask

  task automatic emit(input mouse_pkg::word_t ins);
    prog_q.push_back(ins);
  endtask

  task automatic expect_store(input mouse_pkg::word_t adr, input mouse_pkg::word_t dat);
    st_adr_q.push_back(adr);
    st_dat_q.push_back(dat);
  endtask

  // next fetch address after a fetch of adr
  function automatic mouse_pkg::word_t fetch_after(input mouse_pkg::word_t adr);
    mouse_pkg::bus_req_t t;
    logic                hit;
    hit = 1'b0;
    for (int i = 0; i < mem.trace.size(); i++) begin
      t = mem.trace[i];
      if (t.xen) begin
        if (hit) return t.adr;
        hit = (t.adr == adr);
      end
    end
    return 32'hffff_ffff;  // none found
  endfunction

  task automatic check_x0_writes;
    mouse_pkg::bus_req_t t;
    for (int i = 0; i < mem.trace.size(); i++) begin
      t = mem.trace[i];
      if (t.wen && (t.adr == gpr_adr)) begin
        report_error("a write to the x0 slot appeared on the bus");
      end
    end
    check("x0 slot", mem.gpr[0], mem.fill_word(gpr_adr));
  endtask

  task automatic check_stores;
    mouse_pkg::bus_req_t t;
    int                  n;
    n = 0;
    for (int i = 0; i < mem.trace.size(); i++) begin
      t = mem.trace[i];
      if (t.wen && !t.xen && (t.adr[31:7] != gpr_adr[31:7])) begin
        if (n >= st_adr_q.size()) begin
          report_error("store transfer that the program does not contain");
        end else begin
          check("store adr", t.adr, st_adr_q[n]);
          check("store wdt", t.wdt, st_dat_q[n]);
        end
        n++;
      end
    end
    check("store count", n, st_adr_q.size());
  endtask

  // reset, load, run to the self jump
  task automatic run_program(input logic bp);
    @(negedge clk);
    rst   = 1'b1;
    bp_en = bp;
    for (int i = 0; i < 64; i++) begin
      mem.prog[i] = (i < prog_q.size()) ? prog_q[i] : mem.fill_word(rst_adr + 4 * i);
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;
    #1;
    check("bus_req.vld after reset", bus_req.vld, 0);
    while (!mem.halted) @(negedge clk);
    check_x0_writes();
    check_stores();
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests

  task automatic test_reset;
    mouse_pkg::bus_req_t t;
    new_program();
    emit(enc_j(5'd0, 21'd0));
    run_program(1'b0);
    t = mem.trace[0];
    check("first xen", t.xen, 1);
    check("first wen", t.wen, 0);
    check("first adr", t.adr, rst_adr);
  endtask

  task automatic test_upper(input logic bp);
    new_program();
    emit(enc_u(opc_lui, 5'd1, 20'h12345));
    emit(enc_u(opc_auipc, 5'd2, 20'h00010));  // at +4
    emit(enc_j(5'd3, 21'd8));                 // at +8, skips one
    emit(enc_u(opc_lui, 5'd4, 20'hdead0));
    emit(enc_u(opc_lui, 5'd5, 20'hfffff));
    emit(enc_j(5'd0, 21'd0));
    run_program(bp);
    check_gpr(1, {20'h12345, 12'h000});
    check_gpr(2, rst_adr + 32'd4 + {20'h00010, 12'h000});
    check_gpr(3, rst_adr + 32'd8 + 32'd4);
    check_gpr(4, mem.fill_word(gpr_adr + 32'd16));  // jumped over
    check_gpr(5, {20'hfffff, 12'h000});
    check("fetch after jal", fetch_after(rst_adr + 32'd8), rst_adr + 32'd16);
  endtask

  task automatic test_opimm(input logic bp);
    mouse_pkg::word_t a;
    mouse_pkg::word_t sra;
    new_program();
    emit(enc_u(opc_lui, 5'd1, 20'h87654));
    emit(enc_i(opc_imm, 3'd0, 5'd1, 5'd1, 12'h321));
    emit(enc_i(opc_imm, 3'd0, 5'd2, 5'd1, 12'hffb));   // addi -5
    emit(enc_i(opc_imm, 3'd2, 5'd3, 5'd1, 12'h005));   // slti
    emit(enc_i(opc_imm, 3'd3, 5'd4, 5'd1, 12'h005));   // sltiu
    emit(enc_i(opc_imm, 3'd4, 5'd5, 5'd1, 12'hfff));   // xori
    emit(enc_i(opc_imm, 3'd6, 5'd6, 5'd1, 12'h0f0));   // ori
    emit(enc_i(opc_imm, 3'd7, 5'd7, 5'd1, 12'h7ff));   // andi
    emit(enc_i(opc_imm, 3'd1, 5'd8, 5'd1, 12'h004));   // slli
    emit(enc_i(opc_imm, 3'd5, 5'd9, 5'd1, 12'h008));   // srli
    emit(enc_i(opc_imm, 3'd5, 5'd10, 5'd1, 12'h408));  // srai
    emit(enc_j(5'd0, 21'd0));
    run_program(bp);
    a   = {20'h87654, 12'h000} + sext12(12'h321);
    sra = $signed(a) >>> 8;
    check_gpr(1, a);
    check_gpr(2, a + sext12(12'hffb));
    check_gpr(3, flag($signed(a) < $signed(sext12(12'h005))));
    check_gpr(4, flag(a < sext12(12'h005)));
    check_gpr(5, a ^ sext12(12'hfff));
    check_gpr(6, a | sext12(12'h0f0));
    check_gpr(7, a & sext12(12'h7ff));
    check_gpr(8, a << 4);
    check_gpr(9, a >> 8);
    check_gpr(10, sra);
  endtask

  task automatic test_reg(input logic bp);
    mouse_pkg::word_t a;
    mouse_pkg::word_t b;
    mouse_pkg::word_t c;
    mouse_pkg::word_t sra;
    new_program();
    emit(enc_u(opc_lui, 5'd1, 20'h87654));
    emit(enc_i(opc_imm, 3'd0, 5'd1, 5'd1, 12'h321));
    emit(enc_i(opc_imm, 3'd0, 5'd2, 5'd0, 12'h007));
    emit(enc_i(opc_imm, 3'd0, 5'd11, 5'd0, 12'hffd));
    emit(enc_r(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));    // add
    emit(enc_r(7'h20, 3'd0, 5'd4, 5'd2, 5'd1));    // sub
    emit(enc_r(7'h00, 3'd1, 5'd5, 5'd1, 5'd2));    // sll
    emit(enc_r(7'h00, 3'd5, 5'd6, 5'd1, 5'd2));    // srl
    emit(enc_r(7'h20, 3'd5, 5'd7, 5'd1, 5'd2));    // sra
    emit(enc_r(7'h00, 3'd2, 5'd8, 5'd1, 5'd2));    // slt
    emit(enc_r(7'h00, 3'd3, 5'd9, 5'd1, 5'd2));    // sltu
    emit(enc_r(7'h00, 3'd2, 5'd10, 5'd2, 5'd11));
    emit(enc_r(7'h00, 3'd3, 5'd12, 5'd2, 5'd11));
    emit(enc_r(7'h00, 3'd4, 5'd13, 5'd1, 5'd11));  // xor
    emit(enc_r(7'h00, 3'd6, 5'd14, 5'd1, 5'd2));   // or
    emit(enc_r(7'h00, 3'd7, 5'd15, 5'd1, 5'd11));  // and
    emit(enc_u(opc_lui, 5'd16, data_adr[31:12]));
    emit(enc_s(5'd16, 5'd1, 12'd8));
    emit(enc_s(5'd16, 5'd3, 12'd12));
    emit(enc_i(opc_load, 3'd2, 5'd17, 5'd16, 12'd8));   // reads back the store
    emit(enc_i(opc_load, 3'd2, 5'd18, 5'd16, 12'd20));
    emit(enc_r(7'h00, 3'd0, 5'd19, 5'd0, 5'd1));
    emit(enc_r(7'h00, 3'd0, 5'd0, 5'd1, 5'd2));    // discarded
    emit(enc_j(5'd0, 21'd0));
    a   = {20'h87654, 12'h000} + sext12(12'h321);
    b   = 32'd7;
    c   = sext12(12'hffd);
    sra = $signed(a) >>> b[4:0];
    expect_store(data_adr + 32'd8, a);
    expect_store(data_adr + 32'd12, a + b);
    run_program(bp);
    check_gpr(3, a + b);
    check_gpr(4, b - a);
    check_gpr(5, a << b[4:0]);
    check_gpr(6, a >> b[4:0]);
    check_gpr(7, sra);
    check_gpr(8, flag($signed(a) < $signed(b)));
    check_gpr(9, flag(a < b));
    check_gpr(10, flag($signed(b) < $signed(c)));
    check_gpr(12, flag(b < c));
    check_gpr(13, a ^ c);
    check_gpr(14, a | b);
    check_gpr(15, a & c);
    check_gpr(17, a);
    check_gpr(18, mem.fill_word(data_adr + 32'd20));
    check_gpr(19, a);
  endtask

  // x0 as destination and as source
  task automatic test_x0;
    new_program();
    emit(enc_u(opc_lui, 5'd0, 20'h12345));
    emit(enc_i(opc_imm, 3'd0, 5'd1, 5'd0, 12'h055));
    emit(enc_r(7'h00, 3'd0, 5'd2, 5'd0, 5'd0));
    emit(enc_u(opc_lui, 5'd16, data_adr[31:12]));
    emit(enc_s(5'd16, 5'd0, 12'd16));
    emit(enc_i(opc_load, 3'd2, 5'd0, 5'd16, 12'd16));
    emit(enc_r(7'h20, 3'd0, 5'd3, 5'd0, 5'd1));
    emit(enc_j(5'd0, 21'd0));
    expect_store(data_adr + 32'd16, 32'd0);
    run_program(1'b0);
    check_gpr(1, 32'h55);
    check_gpr(2, 32'd0);
    check_gpr(3, 32'd0 - 32'h55);
  endtask

  initial begin
    rst   = 1'b1;
    bp_en = 1'b0;
    test_reset();
    test_upper(1'b0);
    test_opimm(1'b0);
    test_reg(1'b0);
    test_x0();
    // same programs, random ready
    test_upper(1'b1);
    test_opimm(1'b1);
    test_reg(1'b1);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/mouse_pkg.sv
rtl/mouse_arith.sv
rtl/mouse_bitwise.sv
rtl/mouse_decoder.sv
rtl/mouse_sequencer.sv
rtl/mouse_top.sv
sim/tb_memory.sv
sim/tb_mouse.sv
